// File: design/pe_settings.svh
`ifndef PE_SETTINGS_SVH
`define PE_SETTINGS_SVH

// **************************************************
// Processing element sizing
// **************************************************

`define PE_DATA_WIDTH 16 // Datapath word width
`define PE_ADDR_WIDTH 4  // Register address width
`define PE_NUM_REGS   16 // Register file depth

`endif

// File: design/pe_isa_pkg.sv
`include "pe_settings.svh"

package pe_isa_pkg;

	// **************************************************
	// Opcodes issued by the array controller
	// **************************************************

	typedef enum logic [3:0] {
		NOP   = 4'd0,  // No unit, no write-back
		ADD   = 4'd1,  // ALU, x + y
		SUB   = 4'd2,  // ALU, x - y
		AND   = 4'd3,  // ALU bitwise
		OR    = 4'd4,  // ALU bitwise
		XOR   = 4'd5,  // ALU bitwise
		MUL   = 4'd6,  // Multiplier, signed
		SHL   = 4'd7,  // Shifter, logical left
		SHR   = 4'd8,  // Shifter, logical right
		SRA   = 4'd9,  // Shifter, arithmetic right
		BCAST = 4'd10  // Broadcast word into rd
	} pe_opcode_e;

	// **************************************************
	// Instruction word
	// **************************************************

	typedef struct packed {
		pe_opcode_e                opcode;  // Operation
		logic [`PE_ADDR_WIDTH-1:0] rd;      // Destination register
		logic [`PE_ADDR_WIDTH-1:0] rs_x;    // Source for operand x
		logic [`PE_ADDR_WIDTH-1:0] rs_y;    // Source for operand y
		logic [`PE_DATA_WIDTH-1:0] bc_data; // Broadcast word
	} pe_instr_t;

endpackage

// File: design/pe_datapath_pkg.sv
`include "pe_settings.svh"

package pe_datapath_pkg;

	// Unit select, at most one bit high
	typedef struct packed {
		logic alu; // ALU result
		logic mul; // Multiplier result
		logic shf; // Shifter result
		logic bc;  // Broadcast word
	} unit_en_t;

	// **************************************************
	// Execute stage register contents
	// **************************************************

	typedef struct packed {
		logic                      valid;   // Instruction writes back
		pe_isa_pkg::pe_opcode_e    opcode;  // Operation for ALU and shifter
		logic [`PE_ADDR_WIDTH-1:0] rd;      // Write-back address
		unit_en_t                  unit_en; // Result source
		logic [`PE_DATA_WIDTH-1:0] x;       // Forwarded operand x
		logic [`PE_DATA_WIDTH-1:0] y;       // Forwarded operand y
		logic [`PE_DATA_WIDTH-1:0] bc_data; // Broadcast word
	} exec_stage_t;

	typedef struct packed {
		logic                      valid; // Write pulse
		logic [`PE_ADDR_WIDTH-1:0] addr;  // Register address
		logic [`PE_DATA_WIDTH-1:0] data;  // Result word
	} wb_t;

	typedef struct packed {
		logic alu_saturate; // Signed clamp on ADD and SUB
		logic mul_high;     // Upper product half
	} pe_cfg_t;

endpackage

// File: design/pe_config.sv
`include "pe_settings.svh"

module pe_config
(
	input  logic                     clk,       // Element clock
	input  logic                     reset,     // Sync, active high
	input  logic                     cfg_write, // Load strobe
	input  pe_datapath_pkg::pe_cfg_t cfg_data,  // New mode bits
	output pe_datapath_pkg::pe_cfg_t cfg        // Current mode bits
);

	import pe_datapath_pkg::*;

	// Both modes off after reset
	localparam pe_cfg_t CFG_RESET = '{alu_saturate: 1'b0, mul_high: 1'b0};

	// **************************************************
	// Mode register
	// **************************************************

	always_ff @(posedge clk)
	begin
		if (reset)
			cfg <= CFG_RESET;          // Plain wrap, low half
		else if (cfg_write)
			cfg <= cfg_data;           // Takes effect next cycle
	end

	// Units downstream are combinational, an X here reaches wb
	cfg_known: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(cfg))
		else $error("pe_config: mode bits unknown after reset");

endmodule

// File: design/pe_decoder.sv
`include "pe_settings.svh"

module pe_decoder
(
	input  logic                         clk,         // Element clock
	input  logic                         reset,       // Sync, active high
	input  logic                         instr_valid, // Instruction strobe
	input  pe_isa_pkg::pe_instr_t        instr,       // From array controller
	input  logic [`PE_DATA_WIDTH-1:0]    x_fwd,       // Operand x after forwarding
	input  logic [`PE_DATA_WIDTH-1:0]    y_fwd,       // Operand y after forwarding
	output logic [`PE_ADDR_WIDTH-1:0]    rs_x,        // Read address x
	output logic [`PE_ADDR_WIDTH-1:0]    rs_y,        // Read address y
	output pe_datapath_pkg::exec_stage_t exec         // Execute stage
);

	import pe_isa_pkg::*;
	import pe_datapath_pkg::*;

	unit_en_t                  unit_en_d; // Decoded unit select
	logic                      valid_q;   // Control state
	unit_en_t                  unit_en_q;
	pe_opcode_e                opcode_q;  // Payload, no reset
	logic [`PE_ADDR_WIDTH-1:0] rd_q;
	logic [`PE_DATA_WIDTH-1:0] x_q;
	logic [`PE_DATA_WIDTH-1:0] y_q;
	logic [`PE_DATA_WIDTH-1:0] bc_q;

	assign rs_x = instr.rs_x; // Register file reads in the issue cycle
	assign rs_y = instr.rs_y;

	// **************************************************
	// Opcode to unit select
	// **************************************************

	always_comb
	begin
		unit_en_d = '0;
		if (instr_valid)
		begin
			case (instr.opcode)
				ADD, SUB, AND, OR, XOR: unit_en_d.alu = 1'b1;
				MUL:                    unit_en_d.mul = 1'b1;
				SHL, SHR, SRA:          unit_en_d.shf = 1'b1;
				BCAST:                  unit_en_d.bc  = 1'b1;
				default:                unit_en_d     = '0; // NOP and unused codes
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			valid_q   <= 1'b0;
			unit_en_q <= '0;
		end
		else
		begin
			valid_q   <= |unit_en_d; // Only unit ops write back
			unit_en_q <= unit_en_d;
		end
	end

	always_ff @(posedge clk)
	begin
		if (instr_valid)
		begin
			opcode_q <= instr.opcode;
			rd_q     <= instr.rd;
			x_q      <= x_fwd;         // Already includes wb bypass
			y_q      <= y_fwd;
			bc_q     <= instr.bc_data;
		end
	end

	assign exec = '{valid: valid_q, opcode: opcode_q, rd: rd_q, unit_en: unit_en_q,
		x: x_q, y: y_q, bc_data: bc_q};

	// A stage without a unit must never claim a write-back
	exec_valid_needs_unit: assert property (@(posedge clk) disable iff (reset)
		(exec.unit_en == '0) |-> !exec.valid)
		else $error("pe_decoder: exec valid with no unit enabled");

endmodule

// File: design/register_file.sv
`include "pe_settings.svh"

module register_file
(
	input  logic                      clk,   // Element clock
	input  logic                      reset, // Clears every entry
	input  logic [`PE_ADDR_WIDTH-1:0] rs_x,  // Read address x
	input  logic [`PE_ADDR_WIDTH-1:0] rs_y,  // Read address y
	input  pe_datapath_pkg::wb_t      wb,    // Write port from crossbar
	output logic [`PE_DATA_WIDTH-1:0] rf_x,  // Read data x
	output logic [`PE_DATA_WIDTH-1:0] rf_y   // Read data y
);

	logic [`PE_DATA_WIDTH-1:0] regs [`PE_NUM_REGS]; // Register storage

	// **************************************************
	// Write port
	// **************************************************

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `PE_NUM_REGS; i++)
				regs[i] <= '0;                // Known state for the array
		end
		else if (wb.valid)
			regs[wb.addr] <= wb.data;         // One write per cycle
	end

	// **************************************************
	// Read ports
	// **************************************************

	// Same-cycle write is not visible here, the crossbar bypasses it
	assign rf_x = regs[rs_x];
	assign rf_y = regs[rs_y];

endmodule

// File: design/crossbar.sv
`include "pe_settings.svh"

module crossbar
(
	input  pe_datapath_pkg::exec_stage_t exec,       // Execute stage
	input  logic [`PE_ADDR_WIDTH-1:0]    rs_x,       // Next instruction, source x
	input  logic [`PE_ADDR_WIDTH-1:0]    rs_y,       // Next instruction, source y
	input  logic [`PE_DATA_WIDTH-1:0]    rf_x,       // Register file read x
	input  logic [`PE_DATA_WIDTH-1:0]    rf_y,       // Register file read y
	input  logic [`PE_DATA_WIDTH-1:0]    alu_result, // ALU output
	input  logic [`PE_DATA_WIDTH-1:0]    mul_result, // Multiplier output
	input  logic [`PE_DATA_WIDTH-1:0]    shf_result, // Shifter output
	output logic [`PE_DATA_WIDTH-1:0]    x_fwd,      // Operand x to decoder
	output logic [`PE_DATA_WIDTH-1:0]    y_fwd,      // Operand y to decoder
	output pe_datapath_pkg::wb_t         wb          // Write-back
);

	logic                      wb_en;   // Any unit active
	logic [`PE_DATA_WIDTH-1:0] wb_data; // Selected result
	logic                      hit_x;   // rs_x matches pending write
	logic                      hit_y;

	assign wb_en = |exec.unit_en;

	// **************************************************
	// Result select, order is {alu, mul, shf, bc}
	// **************************************************

	always_comb
	begin
		case (exec.unit_en)
			4'b1000: wb_data = alu_result;
			4'b0100: wb_data = mul_result;
			4'b0010: wb_data = shf_result;
			4'b0001: wb_data = exec.bc_data; // Broadcast bypasses units
			default: wb_data = '0;
		endcase
	end

	assign wb = '{valid: wb_en, addr: exec.rd, data: wb_data};

	// Bypass for a dependent instruction issued right behind
	assign hit_x = wb_en && (rs_x == exec.rd);
	assign hit_y = wb_en && (rs_y == exec.rd);
	assign x_fwd = hit_x ? wb_data : rf_x;
	assign y_fwd = hit_y ? wb_data : rf_y; // rs_x == rs_y gets the same word

	// Decoder promises a single source, anything else loses a result
	always_comb
	begin
		if (!$isunknown(exec.unit_en))
			unit_en_onehot: assert ($onehot0(exec.unit_en))
				else $error("crossbar: more than one unit enabled");
	end

endmodule

// File: design/pe_alu.sv
`include "pe_settings.svh"

module pe_alu
(
	input  pe_isa_pkg::pe_opcode_e    opcode, // From execute stage
	input  logic [`PE_DATA_WIDTH-1:0] x,      // Operand x
	input  logic [`PE_DATA_WIDTH-1:0] y,      // Operand y
	input  pe_datapath_pkg::pe_cfg_t  cfg,    // Uses alu_saturate
	output logic [`PE_DATA_WIDTH-1:0] result  // To crossbar
);

	import pe_isa_pkg::*;

	localparam int MSB = `PE_DATA_WIDTH - 1;

	// Signed limits, 16'h7fff and 16'h8000 at the default width
	localparam logic [`PE_DATA_WIDTH-1:0] SAT_MAX = {1'b0, {MSB{1'b1}}};
	localparam logic [`PE_DATA_WIDTH-1:0] SAT_MIN = {1'b1, {MSB{1'b0}}};

	logic [`PE_DATA_WIDTH-1:0] sum;       // Wrapped x + y
	logic [`PE_DATA_WIDTH-1:0] diff;      // Wrapped x - y
	logic                      sum_ovf;   // Signed overflow on add
	logic                      diff_ovf;  // Signed overflow on subtract
	logic [`PE_DATA_WIDTH-1:0] sat_value; // Clamp follows sign of x

	assign sum  = x + y;
	assign diff = x - y;

	// Like signs in, other sign out
	assign sum_ovf  = (x[MSB] == y[MSB]) && (sum[MSB] != x[MSB]);
	assign diff_ovf = (x[MSB] != y[MSB]) && (diff[MSB] != x[MSB]);

	assign sat_value = x[MSB] ? SAT_MIN : SAT_MAX;

	// **************************************************
	// Operation select
	// **************************************************

	always_comb
	begin
		case (opcode)
			ADD:     result = (cfg.alu_saturate && sum_ovf) ? sat_value : sum;
			SUB:     result = (cfg.alu_saturate && diff_ovf) ? sat_value : diff;
			AND:     result = x & y;
			OR:      result = x | y;
			XOR:     result = x ^ y;
			default: result = '0; // Not an ALU op, crossbar ignores it
		endcase
	end

endmodule

// File: design/pe_multiplier.sv
`include "pe_settings.svh"

module pe_multiplier
(
	input  logic [`PE_DATA_WIDTH-1:0] x,     // Multiplicand, signed
	input  logic [`PE_DATA_WIDTH-1:0] y,     // Multiplier, signed
	input  pe_datapath_pkg::pe_cfg_t  cfg,   // Uses mul_high
	output logic [`PE_DATA_WIDTH-1:0] result // Selected product half
);

	localparam int PROD_W = 2 * `PE_DATA_WIDTH;

	logic signed [PROD_W-1:0] product; // Full signed product

	// **************************************************
	// Single cycle signed multiply
	// **************************************************

	assign product = $signed(x) * $signed(y);

	// High half carries the sign and the fixed-point integer part
	assign result = cfg.mul_high ? product[PROD_W-1:`PE_DATA_WIDTH]
		: product[`PE_DATA_WIDTH-1:0];

endmodule

// File: design/pe_shifter.sv
`include "pe_settings.svh"

module pe_shifter
(
	input  pe_isa_pkg::pe_opcode_e    opcode, // From execute stage
	input  logic [`PE_DATA_WIDTH-1:0] x,      // Value to shift
	input  logic [`PE_DATA_WIDTH-1:0] y,      // Low bits give the amount
	output logic [`PE_DATA_WIDTH-1:0] result  // To crossbar
);

	import pe_isa_pkg::*;

	localparam int SHAMT_W = $clog2(`PE_DATA_WIDTH);

	logic [SHAMT_W-1:0] shamt; // 0 to 15 at the default width

	assign shamt = y[SHAMT_W-1:0]; // Upper bits of y ignored

	// **************************************************
	// Barrel shift
	// **************************************************

	always_comb
	begin
		case (opcode)
			SHL:     result = x << shamt;
			SHR:     result = x >> shamt;          // Zero fill
			SRA:     result = $signed(x) >>> shamt; // Sign fill
			default: result = '0;
		endcase
	end

endmodule

// File: design/pe_top.sv
`include "pe_settings.svh"

module pe_top
(
	input  logic                     clk,         // Element clock
	input  logic                     reset,       // Sync, active high
	input  logic                     instr_valid, // Instruction strobe
	input  pe_isa_pkg::pe_instr_t    instr,       // Instruction word
	input  logic                     cfg_write,   // Config load strobe
	input  pe_datapath_pkg::pe_cfg_t cfg_data,    // Config value
	output pe_datapath_pkg::wb_t     wb           // Write-back pulse
);

	import pe_datapath_pkg::*;

	pe_cfg_t                   cfg;        // Mode bits
	exec_stage_t               exec;       // Execute stage
	logic [`PE_ADDR_WIDTH-1:0] rs_x;       // Read addresses
	logic [`PE_ADDR_WIDTH-1:0] rs_y;
	logic [`PE_DATA_WIDTH-1:0] rf_x;       // Register file data
	logic [`PE_DATA_WIDTH-1:0] rf_y;
	logic [`PE_DATA_WIDTH-1:0] x_fwd;      // Bypassed operands
	logic [`PE_DATA_WIDTH-1:0] y_fwd;
	logic [`PE_DATA_WIDTH-1:0] alu_result; // Unit outputs
	logic [`PE_DATA_WIDTH-1:0] mul_result;
	logic [`PE_DATA_WIDTH-1:0] shf_result;

	// **************************************************
	// Control
	// **************************************************

	pe_config u_config (.clk(clk), .reset(reset), .cfg_write(cfg_write),
		.cfg_data(cfg_data), .cfg(cfg));

	pe_decoder u_decoder (.clk(clk), .reset(reset), .instr_valid(instr_valid),
		.instr(instr), .x_fwd(x_fwd), .y_fwd(y_fwd), .rs_x(rs_x), .rs_y(rs_y),
		.exec(exec));

	register_file u_regfile (.clk(clk), .reset(reset), .rs_x(rs_x), .rs_y(rs_y),
		.wb(wb), .rf_x(rf_x), .rf_y(rf_y));

	// **************************************************
	// Execution units and write-back
	// **************************************************

	pe_alu u_alu (.opcode(exec.opcode), .x(exec.x), .y(exec.y), .cfg(cfg),
		.result(alu_result));

	pe_multiplier u_mul (.x(exec.x), .y(exec.y), .cfg(cfg), .result(mul_result));

	pe_shifter u_shf (.opcode(exec.opcode), .x(exec.x), .y(exec.y),
		.result(shf_result));

	crossbar u_crossbar (.exec(exec), .rs_x(rs_x), .rs_y(rs_y), .rf_x(rf_x),
		.rf_y(rf_y), .alu_result(alu_result), .mul_result(mul_result),
		.shf_result(shf_result), .x_fwd(x_fwd), .y_fwd(y_fwd), .wb(wb));

endmodule

// File: tb/tb_pe_top.sv
`include "pe_settings.svh"

module tb_pe_top;

	import pe_isa_pkg::*;
	import pe_datapath_pkg::*;

	logic                      clk;                          // DUT clock
	logic                      reset;                        // Synchronous active high reset
	logic                      instr_valid;                  // Instruction strobe
	pe_instr_t                 instr;                        // Instruction word
	logic                      cfg_write;                    // Config strobe
	pe_cfg_t                   cfg_data;                     // Config value
	wb_t                       wb;                           // DUT write-back
	logic [`PE_DATA_WIDTH-1:0] shadow_regs [`PE_NUM_REGS];   // Reference register file
	pe_cfg_t                   shadow_cfg = '0;              // Reference mode bits
	wb_t                       exp_wb = '0;                  // Prediction for the bus word
	wb_t                       exp_q = '0;                   // Lined up with DUT wb
	logic [31:0]               lcg_state = 32'h184e0709;     // Random state
	int                        wb_expected = 0;              // Predicted write-backs
	int                        wb_seen = 0;                  // Observed write-backs

	pe_top u_dut (.clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
		.cfg_write(cfg_write), .cfg_data(cfg_data), .wb(wb));

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;                              // Period 40
	end

	always @(posedge clk) exp_q <= exp_wb;                   // One cycle issue to wb

	always @(negedge clk)
	begin
		if (!reset && wb.valid)
			wb_seen++;                                       // Pulses counted mid-cycle
	end

	// **************************************************
	// Reporting
	// **************************************************

	task automatic fail_run();
		$display("Simulation failed");
		$fatal(1, "Stopped at first failure");
	endtask

	task automatic report_mismatch(string name, logic [15:0] expected, logic [15:0] actual);
		$display("Error at time %0t: %s expected %h, actual %h", $time, name, expected,
			actual);
		fail_run();
	endtask

	// **************************************************
	// Write-back checks one cycle after issue
	// **************************************************

	wb_valid_check: assert property (@(posedge clk) disable iff (reset)
		wb.valid == exp_q.valid)
		else report_mismatch("wb.valid", 16'($sampled(exp_q.valid)),
			16'($sampled(wb.valid)));

	wb_addr_check: assert property (@(posedge clk) disable iff (reset)
		exp_q.valid |-> (wb.addr == exp_q.addr))
		else report_mismatch("wb.addr", 16'($sampled(exp_q.addr)),
			16'($sampled(wb.addr)));

	wb_data_check: assert property (@(posedge clk) disable iff (reset)
		exp_q.valid |-> (wb.data == exp_q.data))
		else report_mismatch("wb.data", $sampled(exp_q.data), $sampled(wb.data));

	// **************************************************
	// Reference model
	// **************************************************

	function automatic logic [15:0] next_word();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];                             // High half of the state
	endfunction

	function automatic pe_opcode_e pick_alu_op(logic [2:0] sel);
		case (sel)
			3'd0:    return ADD;
			3'd1:    return SUB;
			3'd2:    return AND;
			3'd3:    return OR;
			default: return XOR;
		endcase
	endfunction

	// Exact sum in 32 bits clamped to the 16 bit signed range
	function automatic logic [15:0] clamp_signed(int s, logic sat);
		if (sat && s > 32767)
			return 16'h7fff;
		if (sat && s < -32768)
			return 16'h8000;
		return s[15:0];
	endfunction

	function automatic wb_t predict_wb(pe_instr_t ins);
		wb_t         w;
		logic [15:0] x;
		logic [15:0] y;
		int          sx;
		int          sy;
		int          p;
		int          i;
		x  = shadow_regs[ins.rs_x];                          // Model already holds forwarded data
		y  = shadow_regs[ins.rs_y];
		sx = {{16{x[15]}}, x};
		sy = {{16{y[15]}}, y};
		w  = '{valid: 1'b1, addr: ins.rd, data: 16'h0};
		case (ins.opcode)
			ADD:   w.data = clamp_signed(sx + sy, shadow_cfg.alu_saturate);
			SUB:   w.data = clamp_signed(sx - sy, shadow_cfg.alu_saturate);
			AND:   w.data = x & y;
			OR:    w.data = x | y;
			XOR:   w.data = x ^ y;
			MUL:
			begin
				p = sx * sy;
				w.data = shadow_cfg.mul_high ? p[31:16] : p[15:0];
			end
			SHL:   w.data = x << y[3:0];
			SHR:   w.data = x >> y[3:0];
			SRA:
			begin
				w.data = x;
				for (i = 0; i < int'(y[3:0]); i++)
					w.data = {w.data[15], w.data[15:1]};     // Sign fill one bit per step
			end
			BCAST: w.data = ins.bc_data;
			default: w = '0;                                 // NOP writes nothing
		endcase
		return w;
	endfunction

	// **************************************************
	// Stimulus tasks driven on the falling edge
	// **************************************************

	task automatic issue(pe_opcode_e op, logic [`PE_ADDR_WIDTH-1:0] rd,
		logic [`PE_ADDR_WIDTH-1:0] sx, logic [`PE_ADDR_WIDTH-1:0] sy, logic [15:0] bc);
		pe_instr_t ins;
		ins = '{opcode: op, rd: rd, rs_x: sx, rs_y: sy, bc_data: bc};
		@(negedge clk);
		instr_valid = 1'b1;
		instr       = ins;
		cfg_write   = 1'b0;
		exp_wb      = predict_wb(ins);
		if (exp_wb.valid)
		begin
			shadow_regs[exp_wb.addr] = exp_wb.data;
			wb_expected++;
		end
	endtask

	task automatic idle_cycles(int n);
		repeat (n)
		begin
			@(negedge clk);
			instr_valid = 1'b0;
			cfg_write   = 1'b0;
			exp_wb      = '0;                                // Bubble without write-back
		end
	endtask

	task automatic write_config(logic saturate, logic high);
		@(negedge clk);
		instr_valid = 1'b0;
		cfg_write   = 1'b1;
		cfg_data    = '{alu_saturate: saturate, mul_high: high};
		shadow_cfg  = cfg_data;                              // Next issue already sees it
		exp_wb      = '0;
	endtask

	task automatic mul_block(int count);
		logic [15:0] x;
		for (int i = 0; i < count; i++)
		begin
			x = next_word();
			if (i % 2 == 1)
				x[15] = 1'b1;                                // Negative multiplicand
			issue(BCAST, 4'd1, 4'd0, 4'd0, x);
			issue(BCAST, 4'd2, 4'd0, 4'd0, next_word());
			issue(MUL, 4'd3, 4'd1, 4'd2, 16'h0);
		end
	endtask

	task automatic alu_pair(pe_opcode_e op, logic [15:0] a, logic [15:0] b);
		issue(BCAST, 4'd9, 4'd0, 4'd0, a);
		issue(BCAST, 4'd10, 4'd0, 4'd0, b);
		issue(op, 4'd11, 4'd9, 4'd10, 16'h0);
	endtask

	task automatic wait_for_writebacks(int max_cycles);
		int n;
		n = 0;
		while (wb_seen != wb_expected && n < max_cycles)
		begin
			@(negedge clk);
			n++;
		end
		if (wb_seen != wb_expected)
		begin
			$display("Timed out waiting for write-backs: expected %0d, saw %0d",
				wb_expected, wb_seen);
			fail_run();
		end
	endtask

	// **************************************************
	// Test sequence
	// **************************************************

	initial
	begin
		logic [15:0]               r;
		logic [15:0]               x;
		logic [`PE_ADDR_WIDTH-1:0] sx;
		logic [`PE_ADDR_WIDTH-1:0] sy;
		logic [`PE_ADDR_WIDTH-1:0] prev_rd;
		reset       = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		cfg_write   = 1'b0;
		cfg_data    = '0;
		for (int i = 0; i < `PE_NUM_REGS; i++)
			shadow_regs[i] = '0;                             // Register file clears on reset
		repeat (10) @(negedge clk);
		reset = 1'b0;

		idle_cycles(3);                                      // Quiet after reset
		for (int i = 0; i < 4; i++)
		begin
			r = next_word();
			issue(NOP, r[3:0], r[7:4], r[11:8], next_word());
		end

		for (int i = 0; i < `PE_NUM_REGS; i++)
			issue(BCAST, 4'(i), 4'd0, 4'd0, next_word());    // Fill every register
		for (int i = 0; i < 40; i++)
		begin
			r = next_word();
			issue(pick_alu_op(r[14:12]), r[3:0], r[7:4], r[11:8], 16'h0);
		end

		prev_rd = 4'd0;                                      // Dependent chains
		for (int i = 0; i < 16; i++)
		begin
			r  = next_word();
			sx = r[7:4];
			sy = r[11:8];
			case (i % 4)
				0:       sx = prev_rd;
				1:       sy = prev_rd;
				2:
				begin
					sx = prev_rd;
					sy = prev_rd;
				end
				default: sy = sx;                            // Same source twice
			endcase
			issue(pick_alu_op(r[14:12]), r[3:0], sx, sy, 16'h0);
			prev_rd = r[3:0];
		end

		mul_block(8);                                        // Low half
		write_config(1'b0, 1'b1);
		mul_block(8);                                        // High half
		write_config(1'b0, 1'b0);

		for (int amt = 0; amt < 16; amt++)
		begin
			x = next_word();
			if (amt % 2 == 0)
				x[15] = 1'b1;                                // Negative x for SRA
			r = next_word();
			issue(BCAST, 4'd4, 4'd0, 4'd0, x);
			issue(BCAST, 4'd5, 4'd0, 4'd0, {r[15:4], 4'(amt)}); // Upper bits junk
			issue(SHL, 4'd6, 4'd4, 4'd5, 16'h0);
			issue(SHR, 4'd7, 4'd4, 4'd5, 16'h0);
			issue(SRA, 4'd8, 4'd4, 4'd5, 16'h0);
		end

		write_config(1'b1, 1'b0);                            // Saturating ALU
		alu_pair(ADD, 16'h7000, 16'h2000);
		alu_pair(ADD, 16'h9000, 16'he000);
		alu_pair(ADD, 16'h7fff, 16'h0001);
		alu_pair(ADD, 16'h1000, 16'h2000);
		alu_pair(ADD, 16'h8000, 16'hffff);
		alu_pair(SUB, 16'h7000, 16'he000);
		alu_pair(SUB, 16'h9000, 16'h2000);
		alu_pair(SUB, 16'h3000, 16'h1000);

		idle_cycles(2);
		wait_for_writebacks(20);
		idle_cycles(2);
		if (wb_seen == wb_expected)
		begin
			$display("Simulation passed");
			$finish;
		end
		else
		begin
			$display("Write-back count is off at the end of the run");
			fail_run();
		end
	end

endmodule

// File: pe_top.f
+incdir+design
design/pe_isa_pkg.sv
design/pe_datapath_pkg.sv
design/pe_config.sv
design/pe_decoder.sv
design/register_file.sv
design/crossbar.sv
design/pe_alu.sv
design/pe_multiplier.sv
design/pe_shifter.sv
design/pe_top.sv
tb/tb_pe_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the PE testbench with Verilator, run it, and judge the result from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_pe_top -f pe_top.f \
	-o tb_pe_top > sim.log 2>&1 \
	&& ./obj_dir/tb_pe_top >> sim.log 2>&1 \
	|| echo "Simulation failed: build or run returned an error" >> sim.log
if grep -q "Simulation failed" sim.log; then
	echo "FAIL (see sim.log)"
	exit 1
fi
echo "PASS"
exit 0
